// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_obj
FLIST ?= flist.f
BUILD ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the fail line"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "variables: VERILATOR TOP FLIST BUILD LOG VFLAGS"

$(BUILD)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD) -o V$(TOP)

test: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "PASS: all tests" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)
	@echo "test passed"

clean:
	rm -rf $(BUILD) $(LOG)

// File: flist.f
+incdir+.
video_pkg.sv
obj_pkg.sv
obj_dma.sv
obj_scan.sv
obj_draw.sv
obj_linebuf.sv
obj_top.sv
obj_checker.sv
tb_obj.sv

// File: obj_checker.sv
`timescale 1ns/1ps
`include "obj_defs.svh"

module obj_checker
	import video_pkg::*, obj_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  video_timing_t      timing,
	input  logic               ok_out,
	input  logic               bus_req,
	input  logic               bus_ack,
	input  logic [6:0]         ab,
	input  logic [7:0]         db,
	input  logic               blen,
	input  logic [`ROM_AW-1:0] rom_addr,
	input  logic [31:0]        rom_data,
	input  obj_pixel_t         pixel,
	output int                 pixel_errors,
	output int                 other_errors,
	output int                 rows_checked,
	output int                 crowded_rows
);

	logic [7:0]         tab_bytes [4*`OBJ_ENTRIES];
	obj_entry_t         model_tab [`OBJ_ENTRIES];
	logic               tab_valid;
	logic [31:0]        rom_seen [int];
	logic [5:0]         exp_row [`H_ACTIVE];
	video_timing_t      tm_d1;
	video_timing_t      tm_d2;
	logic               rst_q;
	logic               ok_q;
	logic               req_q;
	logic               ack_q;
	logic               blen_q;
	logic [6:0]         ab_q;
	logic [`ROM_AW-1:0] rom_addr_q;
	int                 burst_len;

	initial begin
		pixel_errors = 0;
		other_errors = 0;
		rows_checked = 0;
		crowded_rows = 0;
		tab_valid = 1'b0;
		tm_d1 = '0;
		tm_d2 = '0;
		rst_q = 1'b0;
		ok_q = 1'b0;
		req_q = 1'b0;
		ack_q = 1'b0;
		blen_q = 1'b0;
		ab_q = '0;
		rom_addr_q = '0;
		burst_len = 0;
	end

	// bit planes are bytes 3 down to 0, bit 7 is the leftmost pixel
	function automatic logic [3:0] plane_pixel(input logic [31:0] w, input int bit_no);
		return {w[24 + bit_no], w[16 + bit_no], w[8 + bit_no], w[bit_no]};
	endfunction

	task automatic build_row(input int r);
		int                 n;
		int                 sx;
		int                 bit_no;
		logic               half;
		logic               missing;
		logic [3:0]         line;
		logic [3:0]         c;
		logic [`ROM_AW-1:0] a;
		obj_entry_t         e;
		n = 0;
		for (int x = 0; x < `H_ACTIVE; x++) begin
			exp_row[x] = {2'b00, 4'hf};
		end
		// lowest index first, a column taken stays taken
		for (int i = 0; i < `OBJ_ENTRIES; i++) begin
			e = model_tab[i];
			if (!e.hide && r >= int'(e.y) && r < int'(e.y) + 16) begin
				n++;
				if (n <= `OBJ_PER_LINE) begin
					missing = 1'b0;
					line = 4'(r - int'(e.y));
					if (e.vflip) begin
						line = ~line;
					end
					for (int k = 0; k < 16; k++) begin
						sx = int'(e.x) + k;
						half = (k >= 8) ^ e.hflip;
						bit_no = e.hflip ? (k % 8) : 7 - (k % 8);
						a = {e.code, half, line};
						if (sx < `H_ACTIVE && exp_row[sx][3:0] == 4'hf && !missing) begin
							if (!rom_seen.exists(int'(a))) begin
								$display("at %0t: ROM word %h for row %0d, entry %0d was never fetched",
									$time, a, r, i);
								other_errors++;
								missing = 1'b1;
							end else begin
								c = plane_pixel(rom_seen[int'(a)], bit_no);
								if (c != 4'hf) begin
									exp_row[sx] = {e.palette, c};
								end
							end
						end
					end
				end
			end
		end
		if (n > `OBJ_PER_LINE) begin
			crowded_rows++;
		end
	endtask

	always @(negedge clk) begin
		logic [7:0] col;
		logic [5:0] want;
		logic [6:0] ab_want;
		if (rst) begin
			if (rst_q && (bus_req || blen || pixel.valid)) begin
				$display("at %0t: bus_req, blen or pixel.valid is high during reset", $time);
				other_errors++;
			end
		end else begin
			// byte on db belongs to the address of the cycle before
			if (blen_q) begin
				tab_bytes[ab_q] = db;
				burst_len++;
			end
			// ab walks the table from byte 0 while blen is high
			ab_want = blen_q ? ab_q + 7'd1 : 7'd0;
			if (blen && ab !== ab_want) begin
				$display("Mismatch at %0t: ab expected %h got %h", $time, ab_want, ab);
				other_errors++;
			end
			if (!rst_q) begin
				rom_seen[int'(rom_addr_q)] = rom_data;
			end
			if (ok_q && !tm_d1.lvbl && !bus_req) begin
				$display("at %0t: bus_req did not rise after ok_out", $time);
				other_errors++;
			end
			if (bus_req && !req_q && !ok_q) begin
				$display("at %0t: bus_req rose without ok_out", $time);
				other_errors++;
			end
			if (blen && !blen_q) begin
				burst_len = 0;
				if (!ack_q) begin
					$display("at %0t: blen opened without bus_ack", $time);
					other_errors++;
				end
			end
			if (req_q && ack_q && !blen_q && !blen) begin
				$display("at %0t: blen did not open one cycle after bus_ack", $time);
				other_errors++;
			end
			if (!blen && blen_q) begin
				if (burst_len != 4 * `OBJ_ENTRIES) begin
					$display("at %0t: blen lasted %0d cycles instead of %0d", $time, burst_len,
						4 * `OBJ_ENTRIES);
					other_errors++;
				end
				if (bus_req) begin
					$display("at %0t: bus_req stayed high after blen dropped", $time);
					other_errors++;
				end
				for (int i = 0; i < `OBJ_ENTRIES; i++) begin
					model_tab[i] = {tab_bytes[4 * i + 3], tab_bytes[4 * i + 2],
						tab_bytes[4 * i + 1], tab_bytes[4 * i]};
				end
				tab_valid = 1'b1;
			end
			// pixel lags the column by two clocks
			if (pixel.valid !== tm_d2.lhbl) begin
				$display("Mismatch at %0t: pixel.valid expected %b got %b", $time, tm_d2.lhbl,
					pixel.valid);
				pixel_errors++;
			end
			if (tm_d2.lhbl && tm_d2.lvbl && tab_valid) begin
				if (tm_d2.h == 9'd0) begin
					build_row(int'(tm_d2.v));
					rows_checked++;
				end
				col = tm_d2.h[7:0];
				want = exp_row[col];
				if (pixel.colour !== want[3:0] ||
						(want[3:0] != 4'hf && pixel.palette !== want[5:4])) begin
					$display("Mismatch at %0t: pixel row %0d col %0d expected %h got %h", $time,
						tm_d2.v, col, {1'b1, want}, pixel);
					pixel_errors++;
				end
			end
		end
		rst_q = rst;
		ok_q = ok_out;
		req_q = bus_req;
		ack_q = bus_ack;
		blen_q = blen;
		ab_q = ab;
		rom_addr_q = rom_addr;
		tm_d2 = tm_d1;
		tm_d1 = timing;
	end

endmodule

// File: obj_defs.svh
`ifndef OBJ_DEFS_SVH
`define OBJ_DEFS_SVH

// line geometry in pixel clocks
`define H_TOTAL 384
`define H_ACTIVE 256

// frame geometry in lines
`define V_TOTAL 264
`define V_ACTIVE_FIRST 16
`define V_ACTIVE_LAST 239

// object table, four bytes per entry
`define OBJ_ENTRIES 32
`define OBJ_PER_LINE 8

// graphics ROM, 32-bit words
`define ROM_AW 15

`endif

// File: obj_dma.sv
`timescale 1ns/1ps
`include "obj_defs.svh"

module obj_dma
	import video_pkg::*, obj_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  video_timing_t timing,
	input  logic          ok_out,
	input  logic          bus_ack,
	input  logic [7:0]    db,
	output logic          bus_req,
	output logic          blen,
	output logic [6:0]    ab,
	output logic [3:0]    ram_we,
	output logic [4:0]    ram_waddr,
	output obj_word_u     ram_wdata,
	input  obj_ram_rd_t   ram_rd,
	output obj_word_u     ram_q
);

	typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_BUSY} state_t;

	state_t     state;
	logic [6:0] ab_d;
	logic       blen_d;
	obj_word_u  ram [`OBJ_ENTRIES];

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			bus_req <= 1'b0;
			blen <= 1'b0;
			ab <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (ok_out && !timing.lvbl) begin
						bus_req <= 1'b1;
						state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (timing.lvbl) begin
						// blank ended before the grant
						bus_req <= 1'b0;
						state <= ST_IDLE;
					end else if (bus_ack) begin
						blen <= 1'b1;
						ab <= '0;
						state <= ST_BUSY;
					end
				end
				ST_BUSY: begin
					ab <= ab + 7'd1;
					if (ab == 7'(4 * `OBJ_ENTRIES - 1)) begin
						blen <= 1'b0;
						bus_req <= 1'b0;
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// bus data trails the address by one clock
	always_ff @(posedge clk) begin
		if (rst) begin
			blen_d <= 1'b0;
		end else begin
			blen_d <= blen;
		end
	end

	always_ff @(posedge clk) begin
		ab_d <= ab;
	end

	assign ram_we = blen_d ? (4'b0001 << ab_d[1:0]) : 4'd0;
	assign ram_waddr = ab_d[6:2];
	assign ram_wdata = obj_word_u'({4{db}});

	// byte lanes in, whole words out to the scanner
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (ram_we[i]) begin
				ram[ram_waddr].bytes[i] <= ram_wdata.bytes[i];
			end
		end
		ram_q <= ram[ram_rd.idx];
	end

	// blen only opens once the bus was granted
	assert property (@(posedge clk) disable iff (rst) $rose(blen) |-> $past(bus_ack));

endmodule

// File: obj_draw.sv
`timescale 1ns/1ps
`include "obj_defs.svh"

module obj_draw
	import video_pkg::*, obj_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  video_timing_t      timing,
	output logic [2:0]         list_rd_slot,
	input  obj_entry_t         list_q,
	input  logic [3:0]         list_count,
	output logic [`ROM_AW-1:0] rom_addr,
	input  logic [31:0]        rom_data,
	output buf_wr_t            buf_wr
);

	logic        start;
	logic        busy;
	logic        tail;
	logic [2:0]  slot;
	logic [4:0]  cnt;
	logic [7:0]  target;
	obj_entry_t  ent;
	logic [3:0]  row;
	logic [3:0]  row_q;
	logic [31:0] w0;
	logic [31:0] w1;
	logic        emit;
	logic [3:0]  px;
	logic [31:0] word;
	logic [3:0]  colour;
	logic [8:0]  col;

	// four bit planes, one byte each, leftmost pixel in bit 7
	function automatic logic [3:0] pick(input logic [31:0] w, input logic [2:0] i,
			input logic flip);
		logic [2:0] b;
		b = flip ? i : 3'd7 - i;
		return {w[24 + b], w[16 + b], w[8 + b], w[b]};
	endfunction

	assign list_rd_slot = slot;
	assign row = 4'(target - list_q.y) ^ {4{list_q.vflip}};

	always_ff @(posedge clk) begin
		if (rst) begin
			start <= 1'b0;
			busy <= 1'b0;
			tail <= 1'b0;
			slot <= '0;
			cnt <= '0;
			target <= '0;
		end else begin
			start <= timing.hinit;
			tail <= busy && (cnt == 5'd17);
			if (timing.hinit) begin
				target <= timing.v + 8'd1;
			end
			if (start) begin
				// lists swapped on hinit, count is for this row now
				busy <= list_count != 4'd0;
				slot <= 3'(list_count - 4'd1);
				cnt <= '0;
			end else if (busy) begin
				if (cnt == 5'd17) begin
					cnt <= '0;
					if (slot == 3'd0) begin
						busy <= 1'b0;
					end else begin
						slot <= slot - 3'd1;
					end
				end else begin
					cnt <= cnt + 5'd1;
				end
			end
		end
	end

	// left half first, hflip swaps which ROM half that is
	always_ff @(posedge clk) begin
		if (rst) begin
			rom_addr <= '0;
		end else if (busy && cnt == 5'd0) begin
			rom_addr <= {list_q.code, list_q.hflip, row};
		end else if (busy && cnt == 5'd1) begin
			rom_addr <= {ent.code, ~ent.hflip, row_q};
		end
	end

	always_ff @(posedge clk) begin
		if (busy && cnt == 5'd0) begin
			ent <= list_q;
			row_q <= row;
		end
		if (busy && cnt == 5'd2) begin
			w0 <= rom_data;
		end
		if (busy && cnt == 5'd3) begin
			w1 <= rom_data;
		end
	end

	// last pixel of a sprite spills into the next cycle
	assign emit = tail || (busy && cnt >= 5'd3);
	assign px = tail ? 4'd15 : 4'(cnt - 5'd3);
	assign word = px[3] ? w1 : w0;
	assign colour = pick(word, px[2:0], ent.hflip);
	assign col = {1'b0, ent.x} + {5'd0, px};

	always_ff @(posedge clk) begin
		if (rst) begin
			buf_wr.we <= 1'b0;
		end else begin
			buf_wr.we <= emit && (colour != 4'hf) && (col < 9'(`H_ACTIVE));
		end
		buf_wr.x <= col[7:0];
		buf_wr.pix.valid <= 1'b1;
		buf_wr.pix.palette <= ent.palette;
		buf_wr.pix.colour <= colour;
	end

endmodule

// File: obj_linebuf.sv
`timescale 1ns/1ps
`include "obj_defs.svh"

module obj_linebuf
	import video_pkg::*, obj_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  video_timing_t timing,
	input  list_wr_t      list_wr,
	input  logic [2:0]    list_rd_slot,
	output obj_entry_t    list_q,
	output logic [3:0]    list_count,
	input  buf_wr_t       buf_wr,
	output obj_pixel_t    pixel
);

	obj_entry_t lists [3][`OBJ_PER_LINE];
	logic [3:0] counts [3];
	logic [1:0] fill_sel;
	logic [1:0] draw_sel;

	logic [5:0]                cbuf [2][`H_ACTIVE];
	logic [1:0][`H_ACTIVE-1:0] filled;
	logic                      draw_buf;

	logic       rd_en;
	logic       rd_buf;
	logic [7:0] rd_addr;
	logic       er_en;
	logic       er_buf;
	logic [7:0] er_addr;

	// draw reads the list filled on the previous line
	assign draw_sel = (fill_sel == 2'd0) ? 2'd2 : fill_sel - 2'd1;
	assign list_q = lists[draw_sel][list_rd_slot];
	assign list_count = counts[draw_sel];

	always_ff @(posedge clk) begin
		if (rst) begin
			fill_sel <= '0;
			draw_buf <= 1'b0;
			counts <= '{default: '0};
		end else begin
			if (timing.hinit) begin
				fill_sel <= (fill_sel == 2'd2) ? 2'd0 : fill_sel + 2'd1;
				draw_buf <= ~draw_buf;
			end
			if (list_wr.we && list_wr.entry.spare) begin
				counts[fill_sel] <= list_wr.entry.x[3:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (list_wr.we && !list_wr.entry.spare) begin
			lists[fill_sel][list_wr.slot] <= list_wr.entry;
		end
		if (buf_wr.we) begin
			cbuf[draw_buf][buf_wr.x] <= {buf_wr.pix.palette, buf_wr.pix.colour};
		end
	end

	// a clear flag reads as colour 15
	always_ff @(posedge clk) begin
		if (rst) begin
			filled <= '0;
		end else begin
			if (er_en) begin
				filled[er_buf][er_addr] <= 1'b0;
			end
			if (buf_wr.we) begin
				filled[draw_buf][buf_wr.x] <= 1'b1;
			end
		end
	end

	// column address, then data, then erase one clock later
	always_ff @(posedge clk) begin
		rd_addr <= timing.h[7:0];
		rd_buf <= ~draw_buf;
		er_addr <= rd_addr;
		er_buf <= rd_buf;
	end

	// pixel and valid lag h and lhbl by two clocks
	always_ff @(posedge clk) begin
		if (rst) begin
			rd_en <= 1'b0;
			er_en <= 1'b0;
			pixel <= '0;
		end else begin
			rd_en <= timing.lhbl;
			er_en <= rd_en;
			pixel.valid <= rd_en;
			if (rd_en && filled[rd_buf][rd_addr]) begin
				{pixel.palette, pixel.colour} <= cbuf[rd_buf][rd_addr];
			end else begin
				{pixel.palette, pixel.colour} <= {2'b00, 4'hf};
			end
		end
	end

	// drawing never lands in the buffer being shown or erased
	assert property (@(posedge clk) disable iff (rst)
		buf_wr.we |-> !(rd_en && rd_buf == draw_buf) && !(er_en && er_buf == draw_buf));

endmodule

// File: obj_pkg.sv
package obj_pkg;

	// table entry as the CPU lays it out
	typedef struct packed {
		logic [9:0] code;
		logic [1:0] palette;
		logic       vflip;
		logic       hflip;
		logic       spare;
		logic       hide;
		logic [7:0] y;
		logic [7:0] x;
	} obj_entry_t;

	// table byte n of an entry sits in lane n
	typedef union packed {
		logic [3:0][7:0] bytes;
		obj_entry_t      entry;
	} obj_word_u;

	// spare set marks the closing strobe, count in x[3:0]
	typedef struct packed {
		logic       we;
		logic [2:0] slot;
		obj_entry_t entry;
	} list_wr_t;

	typedef struct packed {
		logic [4:0] idx;
	} obj_ram_rd_t;

endpackage

// File: obj_scan.sv
`timescale 1ns/1ps
`include "obj_defs.svh"

module obj_scan
	import video_pkg::*, obj_pkg::*;
(
	input  logic          clk,
	input  logic          rst,
	input  video_timing_t timing,
	output obj_ram_rd_t   ram_rd,
	input  obj_word_u     ram_q,
	output list_wr_t      list_wr,
	output logic [3:0]    list_count
);

	typedef enum logic [1:0] {S_IDLE, S_ADDR, S_CHECK, S_COUNT} state_t;

	state_t     state;
	logic [4:0] idx;
	logic [3:0] found;
	logic [7:0] target;
	logic [7:0] dy;
	logic       hit;
	logic       last;
	obj_entry_t ent;

	assign ram_rd.idx = idx;
	assign ent = ram_q.entry;

	// rows past 255 wrap back to the top
	assign dy = target - ent.y;
	assign hit = !ent.hide && (dy < 8'd16);
	assign last = (idx == 5'(`OBJ_ENTRIES - 1)) ||
		(found + {3'b000, hit} == 4'(`OBJ_PER_LINE));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			idx <= '0;
			found <= '0;
			target <= '0;
			list_count <= '0;
			list_wr <= '0;
		end else begin
			list_wr.we <= 1'b0;
			if (timing.hinit) begin
				// v is the line just starting, the list serves two rows down
				state <= S_ADDR;
				idx <= '0;
				found <= '0;
				target <= timing.v + 8'd2;
			end else begin
				case (state)
					S_ADDR: state <= S_CHECK;
					S_CHECK: begin
						if (hit) begin
							list_wr.we <= 1'b1;
							list_wr.slot <= found[2:0];
							list_wr.entry <= ent;
							list_wr.entry.spare <= 1'b0;
							found <= found + 4'd1;
						end
						if (last) begin
							state <= S_COUNT;
						end else begin
							idx <= idx + 5'd1;
							state <= S_ADDR;
						end
					end
					S_COUNT: begin
						// closing strobe carries the count
						list_wr.we <= 1'b1;
						list_wr.slot <= '0;
						list_wr.entry <= '0;
						list_wr.entry.spare <= 1'b1;
						list_wr.entry.x <= {4'd0, found};
						list_count <= found;
						state <= S_IDLE;
					end
					default: state <= S_IDLE;
				endcase
			end
		end
	end

	// slots fill in order and never go past the eighth
	assert property (@(posedge clk) disable iff (rst)
		list_wr.we && !list_wr.entry.spare |->
			(found == {1'b0, list_wr.slot} + 4'd1) && (found <= 4'(`OBJ_PER_LINE)));

endmodule

// File: obj_top.sv
`timescale 1ns/1ps
`include "obj_defs.svh"

module obj_top
	import video_pkg::*, obj_pkg::*;
(
	input  logic               clk,
	input  logic               rst,
	input  video_timing_t      timing,
	input  logic               ok_out,
	output logic               bus_req,
	input  logic               bus_ack,
	output logic [6:0]         ab,
	input  logic [7:0]         db,
	output logic               blen,
	output logic [`ROM_AW-1:0] rom_addr,
	input  logic [31:0]        rom_data,
	output obj_pixel_t         pixel
);

	obj_ram_rd_t ram_rd;
	obj_word_u   ram_q;
	list_wr_t    list_wr;
	logic [2:0]  list_rd_slot;
	obj_entry_t  list_q;
	logic [3:0]  list_count;
	buf_wr_t     buf_wr;

	obj_dma u_dma (
		.clk       (clk),
		.rst       (rst),
		.timing    (timing),
		.ok_out    (ok_out),
		.bus_ack   (bus_ack),
		.db        (db),
		.bus_req   (bus_req),
		.blen      (blen),
		.ab        (ab),
		.ram_we    (),
		.ram_waddr (),
		.ram_wdata (),
		.ram_rd    (ram_rd),
		.ram_q     (ram_q)
	);

	obj_scan u_scan (
		.clk        (clk),
		.rst        (rst),
		.timing     (timing),
		.ram_rd     (ram_rd),
		.ram_q      (ram_q),
		.list_wr    (list_wr),
		.list_count ()
	);

	obj_draw u_draw (
		.clk          (clk),
		.rst          (rst),
		.timing       (timing),
		.list_rd_slot (list_rd_slot),
		.list_q       (list_q),
		.list_count   (list_count),
		.rom_addr     (rom_addr),
		.rom_data     (rom_data),
		.buf_wr       (buf_wr)
	);

	obj_linebuf u_linebuf (
		.clk          (clk),
		.rst          (rst),
		.timing       (timing),
		.list_wr      (list_wr),
		.list_rd_slot (list_rd_slot),
		.list_q       (list_q),
		.list_count   (list_count),
		.buf_wr       (buf_wr),
		.pixel        (pixel)
	);

endmodule

// File: tb_obj.sv
`timescale 1ns/1ps
`include "obj_defs.svh"

module tb_obj
	import video_pkg::*, obj_pkg::*;
();

	localparam int NUM_FRAMES = 4;
	localparam int FRAME_CYCLES = `V_TOTAL * `H_TOTAL;
	localparam int WATCHDOG_NS = (5 * FRAME_CYCLES + 1000) * 10;

	logic               clk;
	logic               rst;
	video_timing_t      timing;
	logic               ok_out;
	logic               bus_req;
	logic               bus_ack;
	logic [6:0]         ab;
	logic [7:0]         db;
	logic               blen;
	logic [`ROM_AW-1:0] rom_addr;
	logic [31:0]        rom_data;
	obj_pixel_t         pixel;

	int pixel_errors;
	int other_errors;
	int rows_checked;
	int crowded_rows;

	logic [31:0]        lcg_state;
	logic [7:0]         tbl [4*`OBJ_ENTRIES];
	int                 hc;
	int                 vc;
	logic [6:0]         ab_prev;
	logic [`ROM_AW-1:0] rom_prev;
	logic               req_seen;
	int                 ack_left;

	obj_top dut (
		.clk      (clk),
		.rst      (rst),
		.timing   (timing),
		.ok_out   (ok_out),
		.bus_req  (bus_req),
		.bus_ack  (bus_ack),
		.ab       (ab),
		.db       (db),
		.blen     (blen),
		.rom_addr (rom_addr),
		.rom_data (rom_data),
		.pixel    (pixel)
	);

	obj_checker u_checker (
		.clk          (clk),
		.rst          (rst),
		.timing       (timing),
		.ok_out       (ok_out),
		.bus_req      (bus_req),
		.bus_ack      (bus_ack),
		.ab           (ab),
		.db           (db),
		.blen         (blen),
		.rom_addr     (rom_addr),
		.rom_data     (rom_data),
		.pixel        (pixel),
		.pixel_errors (pixel_errors),
		.other_errors (other_errors),
		.rows_checked (rows_checked),
		.crowded_rows (crowded_rows)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// scrambled address, with about a quarter of the pixels forced to 15
	function automatic logic [31:0] rom_word(input logic [`ROM_AW-1:0] a);
		logic [31:0] h;
		logic [31:0] g;
		h = {17'd0, a} * 32'h0019_660d + 32'h3c6e_f35f;
		h = h ^ (h >> 15);
		g = h * 32'h2c1b_3c6d;
		g = g ^ (g >> 12);
		return g | {4{h[23:16] & h[31:24]}};
	endfunction

	task automatic gen_table();
		obj_entry_t  e;
		logic [31:0] r0;
		logic [31:0] r1;
		logic [7:0]  cy;
		logic [7:0]  cx;
		cy = 8'd40 + 8'((lcg_next() >> 16) % 32'd160);
		cx = 8'((lcg_next() >> 16) % 32'd200);
		for (int i = 0; i < `OBJ_ENTRIES; i++) begin
			r0 = lcg_next();
			r1 = lcg_next();
			e = r1;
			e.spare = 1'b0;
			e.x = r0[31:24];
			e.y = r0[23:16];
			e.hide = (r0[7:5] == 3'd0);
			if (i < 4) begin
				// lone sprites, one per flip combination
				e.vflip = i[1];
				e.hflip = i[0];
				e.hide = 1'b0;
				e.y = 8'(24 + 48 * i);
				e.x = 8'(8 + 60 * i);
			end else if (i < 16) begin
				// twelve on nearly the same rows, more than a line can hold
				e.y = cy + {6'd0, r0[14:13]};
				e.x = cx + {3'd0, r0[12:8]};
			end
			for (int n = 0; n < 4; n++) begin
				tbl[4 * i + n] = e[8 * n +: 8];
			end
		end
	endtask

	task automatic step();
		// ROM and bus answer the address of the cycle before
		rom_data = rom_word(rom_prev);
		rom_prev = rom_addr;
		db = tbl[ab_prev];
		ab_prev = ab;
		if (!bus_req) begin
			bus_ack = 1'b0;
			req_seen = 1'b0;
		end else if (!req_seen) begin
			req_seen = 1'b1;
			ack_left = int'((lcg_next() >> 16) % 32'd21);
			bus_ack = (ack_left == 0);
		end else if (!bus_ack) begin
			ack_left--;
			bus_ack = (ack_left == 0);
		end
		hc = (hc == `H_TOTAL - 1) ? 0 : hc + 1;
		if (hc == `H_TOTAL - 1) begin
			// line number moves on together with hinit
			vc = (vc == `V_TOTAL - 1) ? 0 : vc + 1;
		end
		timing.hinit = (hc == `H_TOTAL - 1);
		timing.lhbl = (hc < `H_ACTIVE);
		timing.lvbl = (vc >= `V_ACTIVE_FIRST) && (vc <= `V_ACTIVE_LAST);
		timing.v = 8'(vc);
		timing.h = 9'(hc);
		ok_out = timing.hinit && (vc == `V_ACTIVE_LAST + 1);
		if (ok_out) begin
			gen_table();
		end
	endtask

	initial begin
		int extra;
		extra = 0;
		rst = 1'b1;
		clk = 1'b0;
		timing = '0;
		ok_out = 1'b0;
		bus_ack = 1'b0;
		db = '0;
		rom_data = '0;
		lcg_state = 32'hd7c6_b00e;
		hc = `H_TOTAL - 2;
		vc = `V_TOTAL - 1;
		ab_prev = '0;
		rom_prev = '0;
		req_seen = 1'b0;
		ack_left = 0;
		for (int i = 0; i < 4 * `OBJ_ENTRIES; i++) begin
			tbl[i] = '0;
		end
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (NUM_FRAMES * FRAME_CYCLES) begin
			@(posedge clk);
			#1;
			step();
		end
		if (rows_checked == 0) begin
			$display("no visible row was checked, the table never arrived");
			extra++;
		end
		if (crowded_rows == 0) begin
			$display("no row held more than eight sprites, the line limit went untested");
			extra++;
		end
		$display("errors: %0d pixel, %0d other; rows checked %0d, crowded rows %0d",
			pixel_errors, other_errors + extra, rows_checked, crowded_rows);
		if (pixel_errors + other_errors + extra == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the test sequence finished");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// File: video_pkg.sv
package video_pkg;

	// lhbl is high across the visible columns of every line, lvbl across visible lines
	typedef struct packed {
		logic       hinit;
		logic       lhbl;
		logic       lvbl;
		logic [7:0] v;
		logic [8:0] h;
	} video_timing_t;

	typedef struct packed {
		logic       valid;
		logic [1:0] palette;
		logic [3:0] colour;
	} obj_pixel_t;

	// one pixel into the drawing buffer
	typedef struct packed {
		logic       we;
		logic [7:0] x;
		obj_pixel_t pix;
	} buf_wr_t;

endpackage
